// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

////////////////////////////////////////
// Load/store pipeline sizing
////////////////////////////////////////

// Data and address width
`define MEM_XLEN        64

// Destination register index width
`define MEM_REG_ADDR_W  5

// Bytes per cache word
`define MEM_BYTES       8

// Memory stages between EX and WB
`define MEM_STAGES      3

`endif

// ==== mem_pkg.sv ====
`include "mem_config.svh"

package mem_pkg;

    ////////////////////////////////////////
    // Datapath vectors
    ////////////////////////////////////////

    typedef logic [`MEM_XLEN-1:0]            xlen_t;
    typedef logic [`MEM_REG_ADDR_W-1:0]      reg_addr_t;
    typedef logic [`MEM_BYTES-1:0]           byte_en_t;
    typedef logic [$clog2(`MEM_BYTES)-1:0]   byte_off_t;

    ////////////////////////////////////////
    // Op and cache encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_ALU   = 2'd1,
        KIND_LOAD  = 2'd2,
        KIND_STORE = 2'd3
    } op_kind_t;

    // Same coding as funct3 of the load/store opcodes
    typedef enum logic [2:0] {
        SIZE_B  = 3'd0,
        SIZE_H  = 3'd1,
        SIZE_W  = 3'd2,
        SIZE_D  = 3'd3,
        SIZE_BU = 3'd4,
        SIZE_HU = 3'd5,
        SIZE_WU = 3'd6
    } mem_size_t;

    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_READ  = 2'd1,
        CTRL_WRITE = 2'd2
    } cache_ctrl_t;

    // Number of bytes covered by one access
    function automatic logic [$clog2(`MEM_BYTES):0] access_bytes(input mem_size_t size);
        case (size)
            SIZE_B, SIZE_BU: return 1;
            SIZE_H, SIZE_HU: return 2;
            SIZE_W, SIZE_WU: return 4;
            SIZE_D:          return `MEM_BYTES;
            default:         return 0;
        endcase
    endfunction

    // False when the access runs past the end of the word
    function automatic logic access_fits(input mem_size_t size, input byte_off_t offset);
        return (int'(offset) + int'(access_bytes(size))) <= `MEM_BYTES;
    endfunction

endpackage

// ==== mem_if.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

////////////////////////////////////////
// Op sitting in EX
////////////////////////////////////////

interface mem_ex_if import mem_pkg::*; ();

    op_kind_t   kind;
    mem_size_t  size;
    xlen_t      value;
    xlen_t      store_data;
    reg_addr_t  rd;

    modport stage (
        output kind,
        output size,
        output value,
        output store_data,
        output rd
    );

    modport align (
        input  kind,
        input  size,
        input  value,
        input  store_data,
        input  rd
    );

endinterface

////////////////////////////////////////
// Op sitting in WB
////////////////////////////////////////

interface mem_wb_if import mem_pkg::*; ();

    op_kind_t   kind;
    mem_size_t  size;
    xlen_t      value;
    reg_addr_t  rd;

    modport stage (
        output kind,
        output size,
        output value,
        output rd
    );

    modport align (
        input  kind,
        input  size,
        input  value,
        input  rd
    );

endinterface

// ==== store_align.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module store_align import mem_pkg::*; (
    mem_ex_if.align     ex,
    output cache_ctrl_t cache_ctrl,
    output xlen_t       cache_addr,
    output byte_en_t    cache_byte_en,
    output xlen_t       cache_wdata
);

    byte_off_t              offset;
    logic [`MEM_BYTES:0]    span_mask;
    logic                   fits;

    ////////////////////////////////////////
    // Request type
    ////////////////////////////////////////

    always_comb
    begin
        case (ex.kind)
            KIND_STORE: cache_ctrl = CTRL_WRITE;
            KIND_LOAD:  cache_ctrl = CTRL_READ;
            default:    cache_ctrl = CTRL_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Address and byte lanes
    ////////////////////////////////////////

    assign offset     = ex.value[$bits(byte_off_t)-1:0];
    assign cache_addr = ex.value & ~xlen_t'(`MEM_BYTES - 1);
    assign fits       = access_fits(ex.size, offset);

    // One extra bit so a full doubleword mask does not wrap
    assign span_mask = ((`MEM_BYTES+1)'(1) << access_bytes(ex.size)) - 1'b1;

    always_comb
    begin
        cache_byte_en = '0;
        if (ex.kind == KIND_STORE && fits)
        begin
            cache_byte_en = byte_en_t'(span_mask[`MEM_BYTES-1:0] << offset);
        end
    end

    // Move the low bytes of the store data up to the addressed lane
    assign cache_wdata = ex.store_data << {offset, 3'b000};

endmodule

// ==== load_align.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module load_align import mem_pkg::*; (
    mem_wb_if.align     wb,
    input  xlen_t       cache_data,
    output logic        wb_valid,
    output reg_addr_t   wb_rd,
    output xlen_t       wb_data
);

    byte_off_t  offset;
    xlen_t      shifted;
    xlen_t      load_data;

    ////////////////////////////////////////
    // Writeback control
    ////////////////////////////////////////

    assign wb_valid = (wb.kind == KIND_ALU) || (wb.kind == KIND_LOAD);
    assign wb_rd    = wb.rd;

    ////////////////////////////////////////
    // Byte extraction and extension
    ////////////////////////////////////////

    assign offset  = wb.value[$bits(byte_off_t)-1:0];

    // Addressed byte lands in lane zero
    assign shifted = cache_data >> {offset, 3'b000};

    always_comb
    begin
        load_data = '0;
        if (access_fits(wb.size, offset))
        begin
            case (wb.size)
                SIZE_B:
                begin
                    load_data = {{(`MEM_XLEN-8){shifted[7]}}, shifted[7:0]};
                end
                SIZE_H:
                begin
                    load_data = {{(`MEM_XLEN-16){shifted[15]}}, shifted[15:0]};
                end
                SIZE_W:
                begin
                    load_data = {{(`MEM_XLEN-32){shifted[31]}}, shifted[31:0]};
                end
                SIZE_BU:
                begin
                    load_data = {{(`MEM_XLEN-8){1'b0}}, shifted[7:0]};
                end
                SIZE_HU:
                begin
                    load_data = {{(`MEM_XLEN-16){1'b0}}, shifted[15:0]};
                end
                SIZE_WU:
                begin
                    load_data = {{(`MEM_XLEN-32){1'b0}}, shifted[31:0]};
                end
                // Full word, offset is zero here
                SIZE_D:
                begin
                    load_data = cache_data;
                end
                default:
                begin
                    load_data = '0;
                end
            endcase
        end
    end

    // ALU results pass straight through
    assign wb_data = (wb.kind == KIND_LOAD) ? load_data : wb.value;

endmodule

// ==== mem_stage_pipe.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module mem_stage_pipe import mem_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  logic        op_valid,
    input  op_kind_t    op_kind,
    input  mem_size_t   op_size,
    input  xlen_t       op_value,
    input  xlen_t       op_store_data,
    input  reg_addr_t   op_rd,
    input  logic        cache_ready,
    mem_ex_if.stage     ex,
    mem_wb_if.stage     wb
);

    // Slot 0 is EX, then MEM1..MEM3, last slot is WB
    localparam int DEPTH  = `MEM_STAGES + 2;
    localparam int WB_IDX = DEPTH - 1;

    op_kind_t   kind_q  [DEPTH];
    mem_size_t  size_q  [DEPTH];
    xlen_t      value_q [DEPTH];
    reg_addr_t  rd_q    [DEPTH];
    xlen_t      store_data_q;

    ////////////////////////////////////////
    // Op kind chain
    ////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                kind_q[i] <= KIND_NONE;
            end
        end
        else if (cache_ready)
        begin
            // Empty slot enters EX when nothing is offered
            kind_q[0] <= op_valid ? op_kind : KIND_NONE;
            for (int i = 1; i < DEPTH; i++)
            begin
                kind_q[i] <= kind_q[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // Payload chain
    ////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (cache_ready)
        begin
            size_q[0]    <= op_size;
            value_q[0]   <= op_value;
            rd_q[0]      <= op_rd;
            store_data_q <= op_store_data;
            for (int i = 1; i < DEPTH; i++)
            begin
                size_q[i]  <= size_q[i-1];
                value_q[i] <= value_q[i-1];
                rd_q[i]    <= rd_q[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // Stage views
    ////////////////////////////////////////

    assign ex.kind       = kind_q[0];
    assign ex.size       = size_q[0];
    assign ex.value      = value_q[0];
    assign ex.store_data = store_data_q;
    assign ex.rd         = rd_q[0];

    assign wb.kind  = kind_q[WB_IDX];
    assign wb.size  = size_q[WB_IDX];
    assign wb.value = value_q[WB_IDX];
    assign wb.rd    = rd_q[WB_IDX];

endmodule

// ==== lsu_pipeline.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module lsu_pipeline import mem_pkg::*; (
    input  logic        CLK,
    input  logic        RST,

    // Op entering EX
    input  logic        op_valid,
    input  op_kind_t    op_kind,
    input  mem_size_t   op_size,
    input  xlen_t       op_value,
    input  xlen_t       op_store_data,
    input  reg_addr_t   op_rd,

    // Data cache
    input  logic        cache_ready,
    input  xlen_t       cache_data,
    output cache_ctrl_t cache_ctrl,
    output xlen_t       cache_addr,
    output byte_en_t    cache_byte_en,
    output xlen_t       cache_wdata,

    // Register file write port
    output logic        wb_valid,
    output reg_addr_t   wb_rd,
    output xlen_t       wb_data
);

    mem_ex_if ex_bus ();
    mem_wb_if wb_bus ();

    ////////////////////////////////////////
    // EX to WB registers
    ////////////////////////////////////////

    mem_stage_pipe mem_stage_pipe_inst (
        .CLK            (CLK),
        .RST            (RST),
        .op_valid       (op_valid),
        .op_kind        (op_kind),
        .op_size        (op_size),
        .op_value       (op_value),
        .op_store_data  (op_store_data),
        .op_rd          (op_rd),
        .cache_ready    (cache_ready),
        .ex             (ex_bus.stage),
        .wb             (wb_bus.stage)
    );

    ////////////////////////////////////////
    // Cache request from EX
    ////////////////////////////////////////

    store_align store_align_inst (
        .ex             (ex_bus.align),
        .cache_ctrl     (cache_ctrl),
        .cache_addr     (cache_addr),
        .cache_byte_en  (cache_byte_en),
        .cache_wdata    (cache_wdata)
    );

    ////////////////////////////////////////
    // Writeback value in WB
    ////////////////////////////////////////

    load_align load_align_inst (
        .wb             (wb_bus.align),
        .cache_data     (cache_data),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

// ==== tb_lsu_pipeline.sv ====
`timescale 1ns/100ps
`include "mem_config.svh"

module tb_lsu_pipeline import mem_pkg::*; ();

    localparam int    N_OPS       = 2000;
    localparam int    CLK_PERIOD  = 8;
    localparam int    WATCHDOG_NS = N_OPS * 10 * CLK_PERIOD;
    localparam int    SLOTS       = `MEM_STAGES + 2;
    localparam int    WB          = SLOTS - 1;
    localparam xlen_t MEM_BASE    = 64'h8000_0000_0004_2000;

    logic           CLK;
    logic           RST;
    logic           op_valid;
    op_kind_t       op_kind;
    mem_size_t      op_size;
    xlen_t          op_value;
    xlen_t          op_store_data;
    reg_addr_t      op_rd;
    logic           cache_ready;
    xlen_t          cache_data;
    cache_ctrl_t    cache_ctrl;
    xlen_t          cache_addr;
    byte_en_t       cache_byte_en;
    xlen_t          cache_wdata;
    logic           wb_valid;
    reg_addr_t      wb_rd;
    xlen_t          wb_data;

    // What the DUT samples at the next rising edge
    logic           cur_valid;
    logic           cur_ready;
    op_kind_t       cur_kind;
    mem_size_t      cur_size;
    xlen_t          cur_value;
    xlen_t          cur_sdata;
    reg_addr_t      cur_rd;

    // Model slots, 0 is EX and the last one is WB
    op_kind_t       m_kind  [SLOTS];
    mem_size_t      m_size  [SLOTS];
    xlen_t          m_value [SLOTS];
    reg_addr_t      m_rd    [SLOTS];
    xlen_t          m_word  [SLOTS];
    xlen_t          m_sdata;
    xlen_t          mem     [16];

    logic [15:0]    lfsr_state;
    int             accepted;
    logic           checking;

    lsu_pipeline lsu_pipeline_inst (
        .CLK            (CLK),
        .RST            (RST),
        .op_valid       (op_valid),
        .op_kind        (op_kind),
        .op_size        (op_size),
        .op_value       (op_value),
        .op_store_data  (op_store_data),
        .op_rd          (op_rd),
        .cache_ready    (cache_ready),
        .cache_data     (cache_data),
        .cache_ctrl     (cache_ctrl),
        .cache_addr     (cache_addr),
        .cache_byte_en  (cache_byte_en),
        .cache_wdata    (cache_wdata),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    always #(CLK_PERIOD/2) CLK = ~CLK;

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
    endfunction

    function automatic xlen_t random_bits(input int n);
        xlen_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[`MEM_XLEN-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    ////////////////////////////////////////
    // Expected values
    ////////////////////////////////////////

    function automatic int size_bytes(input mem_size_t size);
        case (size)
            SIZE_B, SIZE_BU: return 1;
            SIZE_H, SIZE_HU: return 2;
            SIZE_W, SIZE_WU: return 4;
            SIZE_D:          return 8;
            default:         return 0;
        endcase
    endfunction

    function automatic byte_en_t expected_lanes(input op_kind_t kind, input mem_size_t size,
                                                input byte_off_t off);
        int       n;
        byte_en_t en;
        en = '0;
        n  = size_bytes(size);
        if (kind == KIND_STORE && int'(off) + n <= `MEM_BYTES)
        begin
            for (int i = 0; i < n; i++)
            begin
                en[int'(off) + i] = 1'b1;
            end
        end
        return en;
    endfunction

    function automatic xlen_t expected_load(input xlen_t word, input mem_size_t size,
                                            input byte_off_t off);
        int    n;
        logic  signed_load;
        logic  fill;
        xlen_t r;
        n = size_bytes(size);
        signed_load = (size == SIZE_B) || (size == SIZE_H) || (size == SIZE_W);
        r = '0;
        // Crossing the word gives zero
        if (n == 0 || int'(off) + n > `MEM_BYTES)
        begin
            return r;
        end
        fill = signed_load & word[8*(int'(off) + n) - 1];
        for (int i = 0; i < `MEM_BYTES; i++)
        begin
            if (i < n)
                r[8*i +: 8] = word[8*(int'(off) + i) +: 8];
            else
                r[8*i +: 8] = {8{fill}};
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Compare and report
    ////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compare_ctrl(input string name, input cache_ctrl_t got, input cache_ctrl_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR %0t %s got %s expected %s",
                                     $time, name, got.name(), exp.name()));
    endtask

    task automatic compare_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic compare_byte_en(input string name, input byte_en_t got, input byte_en_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic compare_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    ////////////////////////////////////////
    // Model and stimulus
    ////////////////////////////////////////

    task automatic advance_model();
        int       idx;
        byte_en_t en;
        xlen_t    wdata;
        if (cur_ready)
        begin
            idx = int'(m_value[0][6:3]);
            // Store hits memory as it leaves EX
            if (m_kind[0] == KIND_STORE)
            begin
                en    = expected_lanes(m_kind[0], m_size[0], m_value[0][2:0]);
                wdata = m_sdata << (8 * int'(m_value[0][2:0]));
                for (int b = 0; b < `MEM_BYTES; b++)
                begin
                    if (en[b])
                        mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
            if (m_kind[0] == KIND_LOAD)
                m_word[0] = mem[idx];
            for (int s = WB; s > 0; s--)
            begin
                m_kind[s]  = m_kind[s-1];
                m_size[s]  = m_size[s-1];
                m_value[s] = m_value[s-1];
                m_rd[s]    = m_rd[s-1];
                m_word[s]  = m_word[s-1];
            end
            m_kind[0]  = cur_valid ? cur_kind : KIND_NONE;
            m_size[0]  = cur_size;
            m_value[0] = cur_value;
            m_rd[0]    = cur_rd;
            m_sdata    = cur_sdata;
            if (cur_valid)
            begin
                accepted++;
            end
        end
    endtask

    task automatic choose_inputs();
        xlen_t r;
        r = random_bits(2);
        cur_ready = (r[1:0] != 2'b00);
        r = random_bits(3);
        cur_valid = (r[2:0] != 3'b000) && (accepted < N_OPS);
        r = random_bits(2);
        cur_kind = op_kind_t'(r[1:0]);
        r = random_bits(3);
        if (cur_kind == KIND_STORE)
            cur_size = mem_size_t'({1'b0, r[1:0]});
        else if (r[2:0] == 3'd7)
            cur_size = SIZE_D;
        else
            cur_size = mem_size_t'(r[2:0]);
        // Small region so loads see earlier stores
        if (cur_kind == KIND_LOAD || cur_kind == KIND_STORE)
            cur_value = MEM_BASE | random_bits(7);
        else
            cur_value = random_bits(64);
        cur_sdata = random_bits(64);
        r = random_bits(5);
        cur_rd = r[4:0];

        op_valid      <= cur_valid;
        op_kind       <= cur_kind;
        op_size       <= cur_size;
        op_value      <= cur_value;
        op_store_data <= cur_sdata;
        op_rd         <= cur_rd;
        cache_ready   <= cur_ready;
        if (m_kind[WB] == KIND_LOAD)
            cache_data <= m_word[WB];
        else
            cache_data <= ~m_value[WB];
    endtask

    function automatic logic pipe_empty();
        for (int s = 0; s < SLOTS; s++)
        begin
            if (m_kind[s] != KIND_NONE)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_outputs();
        cache_ctrl_t exp_ctrl;
        logic        exp_valid;
        case (m_kind[0])
            KIND_STORE: exp_ctrl = CTRL_WRITE;
            KIND_LOAD:  exp_ctrl = CTRL_READ;
            default:    exp_ctrl = CTRL_IDLE;
        endcase
        compare_ctrl("cache_ctrl", cache_ctrl, exp_ctrl);
        compare_byte_en("cache_byte_en", cache_byte_en,
                        expected_lanes(m_kind[0], m_size[0], m_value[0][2:0]));
        if (m_kind[0] != KIND_NONE)
            compare_xlen("cache_addr", cache_addr, {m_value[0][`MEM_XLEN-1:3], 3'b000});
        if (m_kind[0] == KIND_STORE)
            compare_xlen("cache_wdata", cache_wdata, m_sdata << (8 * int'(m_value[0][2:0])));

        exp_valid = (m_kind[WB] == KIND_ALU) || (m_kind[WB] == KIND_LOAD);
        compare_bit("wb_valid", wb_valid, exp_valid);
        if (exp_valid)
        begin
            compare_rd("wb_rd", wb_rd, m_rd[WB]);
            if (m_kind[WB] == KIND_LOAD)
                compare_xlen("wb_data", wb_data,
                             expected_load(m_word[WB], m_size[WB], m_value[WB][2:0]));
            else
                compare_xlen("wb_data", wb_data, m_value[WB]);
        end
    endtask

    always @(negedge CLK)
    begin
        if (checking)
            check_outputs();
    end

    ////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////

    initial
    begin
        CLK           = 1'b0;
        RST           = 1'b1;
        op_valid      = 1'b0;
        op_kind       = KIND_NONE;
        op_size       = SIZE_B;
        op_value      = '0;
        op_store_data = '0;
        op_rd         = '0;
        cache_ready   = 1'b0;
        cache_data    = '0;
        cur_valid     = 1'b0;
        cur_ready     = 1'b0;
        cur_kind      = KIND_NONE;
        cur_size      = SIZE_B;
        cur_value     = '0;
        cur_sdata     = '0;
        cur_rd        = '0;
        lfsr_state    = 16'd62;
        accepted      = 0;
        checking      = 1'b0;
        m_sdata       = '0;
        for (int s = 0; s < SLOTS; s++)
        begin
            m_kind[s]  = KIND_NONE;
            m_size[s]  = SIZE_B;
            m_value[s] = '0;
            m_rd[s]    = '0;
            m_word[s]  = '0;
        end
        // Scrambled byte address as initial contents
        for (int i = 0; i < 16; i++)
        begin
            mem[i] = (MEM_BASE + xlen_t'(i * 8)) * 64'h9E37_79B9_7F4A_7C15;
        end

        repeat (16) @(posedge CLK);
        RST <= 1'b0;
        checking = 1'b1;

        do
        begin
            @(posedge CLK);
            advance_model();
            choose_inputs();
        end
        while (accepted < N_OPS || !pipe_empty());

        $display("Finished with no errors");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        report_failure("Watchdog expired before all ops left the pipeline");
    end

endmodule

// ==== sim.f ====
+incdir+.
mem_pkg.sv
mem_if.sv
store_align.sv
load_align.sv
mem_stage_pipe.sv
lsu_pipeline.sv
tb_lsu_pipeline.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_lsu_pipeline -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_lsu_pipeline)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
